// ==== flist.f ====
+incdir+.
vr_pkg.sv
vr_ifs.sv
vr_apb_regs.sv
vr_line_buffer.sv
vr_row_fetch.sv
vr_scaler.sv
vr_top.sv
tb_axi_mem.sv
tb_vr_top.sv

// ==== tb_vr_top.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

module tb_vr_top;
	localparam int SEED = 32'hbe4cdcc9;
	localparam int NUM_TESTS = 5;
	localparam int APB_LIMIT = 16;
	localparam int FRAME_LIMIT = 20000;

	typedef struct {
		int img_w, img_h, win_l, win_t, win_w, win_h, dst_w, dst_h;
		logic [31:0] frame_addr;
		int count;
	} test_t;

	// image w/h, window left/top/w/h, destination w/h, base address, pixel count.
	test_t tests [NUM_TESTS] = '{
		'{60, 40, 0, 0, 60, 40, 60, 40, 32'h0000_1000, 2400},	// unscaled.
		'{64, 48, 8, 5, 24, 10, 24, 10, 32'h0000_4000, 240},	// crop.
		'{64, 32, 0, 0, 40, 30, 20, 15, 32'h0000_8000, 300},	// half.
		'{48, 36, 4, 2, 40, 30, 28, 17, 32'h0001_0000, 476},
		'{32, 16, 4, 4, 16, 8, 40, 20, 32'h0002_0000, 800}	// upscale.
	};

	logic clk, resetn;
	logic [31:0] paddr, pwdata, prdata;
	logic psel, penable, pwrite, pready, pslverr;
	logic [31:0] araddr, rdata;
	logic [7:0] arlen, tdata;
	logic [2:0] arsize;
	logic [1:0] arburst, rresp;
	logic arvalid, arready, rlast, rvalid, rready;
	logic tvalid, tuser, tlast, tready;
	integer seed;
	int errors, pix_cnt, cur, tests_run;
	logic timed_out;

	assign rresp = 2'b00;

	vr_top i_vr_top (.*);

	tb_axi_mem #(.SEED(SEED)) i_mem (
		.clk(clk), .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		#10 tready = resetn && (($random(seed) & 3) != 0);	// stall about one cycle in four.
	end

	function automatic logic [7:0] expected_pixel(input int t, input int x, input int y);
		int sx;
		int sy;
		logic [31:0] a;
		sx = x * tests[t].win_w / tests[t].dst_w;	// floor of the scaled position.
		sy = y * tests[t].win_h / tests[t].dst_h;
		a = tests[t].frame_addr + (tests[t].win_t + sy) * tests[t].img_w + tests[t].win_l + sx;
		return 8'(a * 7 + 3);
	endfunction

	task automatic check_beat(input int x, input int y);
		logic [7:0] want;
		want = expected_pixel(cur, x, y);
		assert (pix_cnt < tests[cur].count) else begin
			$display("mismatch at %0t: pixel beyond the %0d expected", $time, tests[cur].count);
			errors++;
		end
		assert (tdata === want) else begin
			$display("mismatch at %0t: pixel (%0d,%0d) is %h, expected %h", $time, x, y, tdata, want);
			errors++;
		end
		assert (tuser === (pix_cnt == 0)) else begin
			$display("mismatch at %0t: tuser is %b on pixel %0d", $time, tuser, pix_cnt);
			errors++;
		end
		assert (tlast === (x == tests[cur].dst_w - 1)) else begin
			$display("mismatch at %0t: tlast is %b on pixel (%0d,%0d)", $time, tlast, x, y);
			errors++;
		end
	endtask

	// a beat moves on the next edge when both are high here.
	always @(negedge clk) begin
		if (tvalid === 1'b1 && tready === 1'b1) begin
			check_beat(pix_cnt % tests[cur].dst_w, pix_cnt / tests[cur].dst_w);
			pix_cnt++;
		end
	end

	// every read request asks for 4-byte beats in an incrementing burst.
	always @(negedge clk) begin
		if (arvalid === 1'b1) begin
			assert (arsize === 3'b010 && arburst === 2'b01) else begin
				$display("mismatch at %0t: arsize %b, arburst %b on request to %h", $time,
					arsize, arburst, araddr);
				errors++;
			end
		end
	end

	task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rd);
		int n;
		paddr = 32'(addr);
		pwdata = wdata;
		pwrite = write;
		psel = 1'b1;
		@(posedge clk);
		#10 penable = 1'b1;
		n = 0;
		while (!pready && n < APB_LIMIT) begin
			@(posedge clk);
			#10 n++;
		end
		if (!pready) begin
			$display("timeout: apb slave held pready low at %0t", $time);
			timed_out = 1'b1;
		end
		rd = prdata;
		assert (pslverr === 1'b0) else begin
			$display("mismatch at %0t: pslverr is %b on access to %h", $time, pslverr, addr);
			errors++;
		end
		@(posedge clk);
		#10 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic run_test(input int t);
		logic [7:0] offs [9];
		logic [31:0] vals [9];
		logic [31:0] rd;
		int n;
		int errs_before;
		offs = '{`VR_REG_IMG_W, `VR_REG_IMG_H, `VR_REG_WIN_L, `VR_REG_WIN_T, `VR_REG_WIN_W,
			`VR_REG_WIN_H, `VR_REG_DST_W, `VR_REG_DST_H, `VR_REG_FRAME_ADDR};
		vals = '{tests[t].img_w, tests[t].img_h, tests[t].win_l, tests[t].win_t, tests[t].win_w,
			tests[t].win_h, tests[t].dst_w, tests[t].dst_h, tests[t].frame_addr};
		errs_before = errors;
		cur = t;
		pix_cnt = 0;
		for (int i = 0; i < 9; i++) begin
			apb_xfer(1'b1, offs[i], vals[i], rd);
		end
		for (int i = 0; i < 9; i++) begin
			apb_xfer(1'b0, offs[i], '0, rd);
			assert (rd === vals[i]) else begin
				$display("mismatch at %0t: register %h reads %h, expected %h", $time, offs[i], rd,
					vals[i]);
				errors++;
			end
		end
		apb_xfer(1'b1, `VR_REG_CTRL, 32'h1, rd);
		apb_xfer(1'b0, `VR_REG_STATUS, '0, rd);
		assert (rd[0] === 1'b1) else begin
			$display("mismatch at %0t: status not busy after start", $time);
			errors++;
		end
		apb_xfer(1'b1, `VR_REG_CTRL, 32'h1, rd);	// must not restart the frame.
		n = 0;
		do begin
			apb_xfer(1'b0, `VR_REG_STATUS, '0, rd);
			n++;
		end while (rd[0] !== 1'b0 && n < FRAME_LIMIT);
		if (rd[0] !== 1'b0 || timed_out) begin
			$display("timeout: test %0d still busy after %0d polls, %0d pixels seen", t, n, pix_cnt);
			timed_out = 1'b1;
			errors++;
			return;
		end
		assert (pix_cnt == tests[t].count) else begin
			$display("mismatch at %0t: %0d pixels, expected %0d", $time, pix_cnt, tests[t].count);
			errors++;
		end
		$display("test %0d: %0dx%0d to %0dx%0d, %0d pixels, %0d errors", t, tests[t].win_w,
			tests[t].win_h, tests[t].dst_w, tests[t].dst_h, pix_cnt, errors - errs_before);
	endtask

	initial begin
		seed = SEED;
		resetn = 1'b0;
		paddr = '0;
		pwdata = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		tready = 1'b0;
		errors = 0;
		pix_cnt = 0;
		cur = 0;
		tests_run = 0;
		timed_out = 1'b0;
		repeat (8) @(posedge clk);
		#10 resetn = 1'b1;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			run_test(t);
			tests_run++;
		end
		$display("%0d of %0d tests run, %0d errors", tests_run, NUM_TESTS, errors);
		if (errors == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem #(
	parameter int SEED = 32'hbe4cdcc9
) (
	input  logic clk,
	input  logic [31:0] araddr,
	input  logic [7:0] arlen,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic rvalid,
	output logic rlast,
	input  logic rready
);
	integer seed;
	logic [31:0] addr;
	int beats_left;
	logic ar_hs;
	logic r_hs;

	// each byte lane carries (address * 7 + 3) mod 256.
	function automatic logic [31:0] word_at(input logic [31:0] a);
		logic [31:0] w;
		for (int k = 0; k < 4; k++) begin
			w[8*k +: 8] = 8'((a + k) * 7 + 3);
		end
		return w;
	endfunction

	initial begin
		seed = SEED;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		addr = '0;
		beats_left = 0;
		forever begin
			@(negedge clk);
			ar_hs = arvalid && arready;	// what the next edge will see.
			r_hs = rvalid && rready;
			@(posedge clk);
			#10;
			if (r_hs) begin
				addr = addr + 4;
				beats_left = beats_left - 1;
			end
			if (ar_hs) begin
				addr = araddr;
				beats_left = arlen + 1;
			end
			arready = (beats_left == 0) && (($random(seed) & 3) != 0);
			rvalid = (beats_left != 0) && ((rvalid && !r_hs) || (($random(seed) & 3) != 0));
			rdata = word_at(addr);
			rlast = (beats_left == 1);
		end
	end

endmodule

// ==== vr_top.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

module vr_top import vr_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  logic [`VR_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`VR_DATA_W-1:0] pwdata,
	output logic [`VR_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [`VR_ADDR_W-1:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input  logic arready,
	input  logic [`VR_DATA_W-1:0] rdata,
	input  logic [1:0] rresp,	// not checked.
	input  logic rlast,
	input  logic rvalid,
	output logic rready,
	output logic tvalid,
	output logic [7:0] tdata,
	output logic tuser,
	output logic tlast,
	input  logic tready
);
	vr_cfg_t cfg;
	logic start;
	logic busy_fetch;
	logic busy_scale;

	line_wr_if wr_lines [`VR_NUM_LINES] ();
	line_rd_if rd_lines [`VR_NUM_LINES] ();

	assign pslverr = 1'b0;
	assign arsize = 3'b010;	// 4 bytes per beat.
	assign arburst = 2'b01;	// incr.

	vr_apb_regs i_regs (
		.clk(clk), .resetn(resetn),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.busy_fetch(busy_fetch), .busy_scale(busy_scale),
		.prdata(prdata), .pready(pready), .cfg(cfg), .start(start)
	);

	vr_row_fetch i_fetch (
		.clk(clk), .resetn(resetn), .cfg(cfg), .start(start),
		.arready(arready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .rready(rready),
		.busy(busy_fetch), .lines(wr_lines)
	);

	for (genvar i = 0; i < `VR_NUM_LINES; i++) begin : g_buf
		vr_line_buffer #(.payload_t(word_t)) i_line (
			.clk(clk), .resetn(resetn), .wr(wr_lines[i]), .rd(rd_lines[i])
		);
	end

	vr_scaler i_scaler (
		.clk(clk), .resetn(resetn), .cfg(cfg), .start(start), .tready(tready),
		.tdata(tdata), .tvalid(tvalid), .tuser(tuser), .tlast(tlast),
		.busy(busy_scale), .lines(rd_lines)
	);

endmodule

// ==== vr_scaler.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

module vr_scaler import vr_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  vr_cfg_t cfg,
	input  logic start,
	input  logic tready,
	output pixel_t tdata,
	output logic tvalid,
	output logic tuser,
	output logic tlast,
	output logic busy,
	line_rd_if.master lines [`VR_NUM_LINES]
);
	localparam int ACC_W = 2 * `VR_DIM_W;

	scale_state_t state;
	logic [`VR_SEL_W-1:0] rd_idx;
	dim_t x, y;	// output position.
	dim_t sx, sy;	// source position inside the window.
	logic [ACC_W-1:0] col_acc, col_lim;	// x * win_w against (sx + 1) * dst_w.
	logic [ACC_W-1:0] row_acc, row_lim;
	logic [`VR_LINE_AW-1:0] rd_addr, prev_addr;
	logic prev_valid;
	logic [`VR_NUM_LINES-1:0] ready_vec;
	word_t rd_vec [`VR_NUM_LINES];
	word_t rd_word;
	logic row_used, col_step, data_ok, load, row_end, rel;

	assign rd_addr = sx[`VR_LINE_AW+1:2];

	for (genvar i = 0; i < `VR_NUM_LINES; i++) begin : g_lines
		assign lines[i].rd_addr = rd_addr;
		assign lines[i].rd_release = rel && (rd_idx == `VR_SEL_W'(i));
		assign ready_vec[i] = lines[i].ready;
		assign rd_vec[i] = lines[i].rd_data;
	end

	assign rd_word = rd_vec[rd_idx];
	assign row_used = (row_acc < row_lim);
	assign col_step = (col_acc >= col_lim);
	assign data_ok = prev_valid && (prev_addr == rd_addr);	// read port caught up with sx.
	assign load = (state == S_EMIT) && !col_step && data_ok && (!tvalid || tready);
	assign row_end = (x == dim_t'(cfg.dst_width - 1'b1));
	assign rel = (state == S_WAIT_ROW) && ready_vec[rd_idx] && !row_used;
	assign busy = (state != S_IDLE) || tvalid;

	always_ff @(posedge clk) begin
		prev_addr <= rd_addr;
		if (load) begin
			tdata <= rd_word[{sx[1:0], 3'b000} +: 8];
			tuser <= (x == '0) && (y == '0);
			tlast <= row_end;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_IDLE;
			rd_idx <= '0;
			tvalid <= 1'b0;
			prev_valid <= 1'b0;
		end else begin
			prev_valid <= (state == S_EMIT);
			if (load) begin
				tvalid <= 1'b1;
			end else if (tready) begin
				tvalid <= 1'b0;
			end
			if ((state == S_IDLE && start) || (load && row_end)) begin
				x <= '0;
				sx <= '0;
				col_acc <= '0;
				col_lim <= ACC_W'(cfg.dst_width);
			end
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_WAIT_ROW;
						y <= '0;
						sy <= '0;
						row_acc <= '0;
						row_lim <= ACC_W'(cfg.dst_height);
					end
				end
				S_WAIT_ROW: begin
					if (ready_vec[rd_idx]) begin
						if (row_used) begin
							state <= S_EMIT;
						end else begin
							sy <= sy + 1'b1;	// unused rows are dropped here too.
							row_lim <= row_lim + ACC_W'(cfg.dst_height);
							rd_idx <= next_line(rd_idx);
							if (sy == dim_t'(cfg.win_height - 1'b1)) begin
								state <= S_IDLE;
							end
						end
					end
				end
				S_EMIT: begin
					if (col_step) begin
						sx <= sx + 1'b1;
						col_lim <= col_lim + ACC_W'(cfg.dst_width);
					end else if (load && row_end) begin
						state <= S_WAIT_ROW;
						y <= y + 1'b1;
						row_acc <= row_acc + ACC_W'(cfg.win_height);
					end else if (load) begin
						x <= x + 1'b1;
						col_acc <= col_acc + ACC_W'(cfg.win_width);
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// stream payload holds while the sink stalls.
	a_axis_hold: assert property (@(posedge clk) disable iff (!resetn)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast));

endmodule

// ==== vr_row_fetch.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

module vr_row_fetch import vr_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  vr_cfg_t cfg,
	input  logic start,
	input  logic arready,
	input  word_t rdata,
	input  logic rvalid,
	input  logic rlast,
	output logic [`VR_ADDR_W-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	output logic rready,
	output logic busy,
	line_wr_if.master lines [`VR_NUM_LINES]
);
	fetch_state_t state;
	logic [`VR_SEL_W-1:0] wr_idx;
	dim_t row;
	dim_t word_idx;	// words of this row already requested and written.
	dim_t words_row;
	dim_t words_left;
	logic [`VR_ADDR_W-1:0] row_base;
	logic [`VR_NUM_LINES-1:0] free_vec;
	logic beat;
	logic row_done;

	assign words_row = cfg.win_width >> 2;
	assign words_left = words_row - word_idx;
	assign arlen = (words_left > `VR_BURST_LEN) ? 8'(`VR_BURST_LEN - 1) :
		8'(words_left - 1'b1);	// short last burst.
	assign araddr = row_base + `VR_ADDR_W'({word_idx, 2'b00});
	assign arvalid = (state == F_ADDR);
	assign rready = (state == F_DATA);
	assign busy = (state != F_IDLE);
	assign beat = rready && rvalid;
	assign row_done = beat && rlast && (word_idx == dim_t'(words_row - 1'b1));

	for (genvar i = 0; i < `VR_NUM_LINES; i++) begin : g_lines
		assign lines[i].wr_en = beat && (wr_idx == `VR_SEL_W'(i));
		assign lines[i].wr_addr = word_idx[`VR_LINE_AW-1:0];
		assign lines[i].wr_data = rdata;
		assign lines[i].wr_done = row_done && (wr_idx == `VR_SEL_W'(i));
		assign free_vec[i] = lines[i].free;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= F_IDLE;
			wr_idx <= '0;
		end else begin
			case (state)
				F_IDLE: begin
					if (start) begin
						state <= F_WAIT_BUF;
						row <= '0;
						row_base <= cfg.frame_addr +
							`VR_ADDR_W'(cfg.win_top) * `VR_ADDR_W'(cfg.img_width) +
							`VR_ADDR_W'(cfg.win_left);
					end
				end
				F_WAIT_BUF: begin
					if (free_vec[wr_idx]) begin
						state <= F_ADDR;
						word_idx <= '0;
					end
				end
				F_ADDR: begin
					if (arready) begin
						state <= F_DATA;
					end
				end
				F_DATA: begin
					if (beat) begin
						word_idx <= word_idx + 1'b1;
						if (row_done) begin
							wr_idx <= next_line(wr_idx);
							row <= row + 1'b1;
							row_base <= row_base + `VR_ADDR_W'(cfg.img_width);	// stride = width.
							state <= (row == dim_t'(cfg.win_height - 1'b1)) ? F_IDLE : F_WAIT_BUF;
						end else if (rlast) begin
							state <= F_ADDR;
						end
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	// the address channel holds its request until the memory takes it.
	a_ar_stable: assert property (@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

// ==== vr_line_buffer.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

module vr_line_buffer import vr_pkg::*; #(
	parameter type payload_t = word_t
) (
	input  logic clk,
	input  logic resetn,
	line_wr_if.target wr,
	line_rd_if.target rd
);
	payload_t mem [`VR_LINE_WORDS];
	payload_t rd_q;
	logic free_q;	// empty, open for the fill engine.
	logic ready_q;	// full, owned by the scaler.

	always_ff @(posedge clk) begin
		if (wr.wr_en) begin
			mem[wr.wr_addr] <= wr.wr_data;
		end
		rd_q <= mem[rd.rd_addr];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			free_q <= 1'b0;
			ready_q <= 1'b0;
		end else if (wr.wr_done) begin
			free_q <= 1'b0;
			ready_q <= 1'b1;
		end else if (rd.rd_release) begin
			free_q <= 1'b1;
			ready_q <= 1'b0;
		end else if (!free_q && !ready_q) begin
			free_q <= 1'b1;	// first cycle out of reset.
		end
	end

	assign wr.free = free_q;
	assign rd.ready = ready_q;
	assign rd.rd_data = rd_q;

	// the fill engine only touches a buffer the scaler has handed back.
	a_wr_free: assert property (@(posedge clk) disable iff (!resetn)
		wr.wr_en |-> free_q);

	a_rel_ready: assert property (@(posedge clk) disable iff (!resetn)
		rd.rd_release |-> ready_q && !wr.wr_done);

endmodule

// ==== vr_apb_regs.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

module vr_apb_regs import vr_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  logic [`VR_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`VR_DATA_W-1:0] pwdata,
	input  logic busy_fetch,
	input  logic busy_scale,
	output logic [`VR_DATA_W-1:0] prdata,
	output logic pready,
	output vr_cfg_t cfg,
	output logic start
);
	logic [7:0] reg_addr;
	logic wr_acc;
	logic busy;

	assign reg_addr = paddr[7:0];
	assign wr_acc = psel && penable && pwrite;
	assign busy = busy_fetch || busy_scale;
	assign pready = 1'b1;
	assign start = wr_acc && (reg_addr == `VR_REG_CTRL) && pwdata[0] && !busy;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg <= '0;
		end else if (wr_acc) begin
			case (reg_addr)
				`VR_REG_IMG_W: cfg.img_width <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_IMG_H: cfg.img_height <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_WIN_L: cfg.win_left <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_WIN_T: cfg.win_top <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_WIN_W: cfg.win_width <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_WIN_H: cfg.win_height <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_DST_W: cfg.dst_width <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_DST_H: cfg.dst_height <= pwdata[`VR_DIM_W-1:0];
				`VR_REG_FRAME_ADDR: cfg.frame_addr <= pwdata;
				default: ;
			endcase
		end
	end

	always_comb begin
		prdata = '0;
		if (psel) begin
			case (reg_addr)
				`VR_REG_STATUS: prdata[0] = busy;
				`VR_REG_IMG_W: prdata = `VR_DATA_W'(cfg.img_width);
				`VR_REG_IMG_H: prdata = `VR_DATA_W'(cfg.img_height);
				`VR_REG_WIN_L: prdata = `VR_DATA_W'(cfg.win_left);
				`VR_REG_WIN_T: prdata = `VR_DATA_W'(cfg.win_top);
				`VR_REG_WIN_W: prdata = `VR_DATA_W'(cfg.win_width);
				`VR_REG_WIN_H: prdata = `VR_DATA_W'(cfg.win_height);
				`VR_REG_DST_W: prdata = `VR_DATA_W'(cfg.dst_width);
				`VR_REG_DST_H: prdata = `VR_DATA_W'(cfg.dst_height);
				`VR_REG_FRAME_ADDR: prdata = cfg.frame_addr;
				default: prdata = '0;	// ctrl reads as zero.
			endcase
		end
	end

	// both engines pick up a start.
	a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
		start |=> (busy_fetch && busy_scale));

endmodule

// ==== vr_ifs.sv ====
`include "vr_consts.svh"
`timescale 1ns/1ps

interface line_wr_if import vr_pkg::*; #(
	parameter type payload_t = word_t
);
	logic wr_en;
	logic [`VR_LINE_AW-1:0] wr_addr;
	payload_t wr_data;
	logic wr_done;	// row complete.
	logic free;

	modport master (output wr_en, wr_addr, wr_data, wr_done, input free);
	modport target (input wr_en, wr_addr, wr_data, wr_done, output free);
endinterface

interface line_rd_if import vr_pkg::*; #(
	parameter type payload_t = word_t
);
	logic [`VR_LINE_AW-1:0] rd_addr;
	logic rd_release;	// one cycle, hands the row back.
	payload_t rd_data;	// one cycle after rd_addr.
	logic ready;

	modport master (output rd_addr, rd_release, input rd_data, ready);
	modport target (input rd_addr, rd_release, output rd_data, ready);
endinterface

// ==== vr_pkg.sv ====
`include "vr_consts.svh"

package vr_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic [`VR_DATA_W-1:0] word_t;	// pixel 0 in the low byte.
	typedef logic [`VR_DIM_W-1:0] dim_t;

	typedef struct packed {
		dim_t img_width;
		dim_t img_height;
		dim_t win_left;
		dim_t win_top;
		dim_t win_width;
		dim_t win_height;
		dim_t dst_width;
		dim_t dst_height;
		logic [`VR_ADDR_W-1:0] frame_addr;
	} vr_cfg_t;

	typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA, F_WAIT_BUF} fetch_state_t;
	typedef enum logic [1:0] {S_IDLE, S_WAIT_ROW, S_EMIT} scale_state_t;

	// both engines walk the line buffers in the same order.
	function automatic logic [`VR_SEL_W-1:0] next_line(input logic [`VR_SEL_W-1:0] idx);
		return (idx == `VR_SEL_W'(`VR_NUM_LINES - 1)) ? '0 : idx + 1'b1;
	endfunction

endpackage

// ==== vr_consts.svh ====
`ifndef VR_CONSTS_SVH
`define VR_CONSTS_SVH

`define VR_DATA_W	32
`define VR_ADDR_W	32
`define VR_DIM_W	12
`define VR_BURST_LEN	4
`define VR_NUM_LINES	2
`define VR_LINE_WORDS	1024
`define VR_LINE_AW	($clog2(`VR_LINE_WORDS))
`define VR_SEL_W	($clog2(`VR_NUM_LINES))

// apb register map, byte offsets.
`define VR_REG_CTRL	8'h00
`define VR_REG_STATUS	8'h04
`define VR_REG_IMG_W	8'h08
`define VR_REG_IMG_H	8'h0C
`define VR_REG_WIN_L	8'h10
`define VR_REG_WIN_T	8'h14
`define VR_REG_WIN_W	8'h18
`define VR_REG_WIN_H	8'h1C
`define VR_REG_DST_W	8'h20
`define VR_REG_DST_H	8'h24
`define VR_REG_FRAME_ADDR	8'h28

`endif
